//--- source/tg_csr_pkg.sv
// Host register map of the traffic generator subsystem
// Host bus request and response words, plus the control register layout

package tg_csr_pkg;

   //------------------------------
   // Host bus widths
   //------------------------------
   localparam int CSR_AW = 8;
   localparam int CSR_DW = 32;

   // Word addresses
   localparam logic [CSR_AW-1:0] ADDR_CTRL    = 8'h00;
   localparam logic [CSR_AW-1:0] ADDR_SEED0   = 8'h01;
   localparam logic [CSR_AW-1:0] ADDR_SEED1   = 8'h02;
   localparam logic [CSR_AW-1:0] ADDR_STATUS  = 8'h04;
   localparam logic [CSR_AW-1:0] ADDR_CYCLES0 = 8'h05;
   localparam logic [CSR_AW-1:0] ADDR_CYCLES1 = 8'h06;
   localparam logic [CSR_AW-1:0] ADDR_ERRCNT0 = 8'h07;
   localparam logic [CSR_AW-1:0] ADDR_ERRCNT1 = 8'h08;

   typedef struct packed {
      logic              write;
      logic              read;
      logic [CSR_AW-1:0] addr;
      logic [CSR_DW-1:0] wdata;
   } csr_req_t;

   typedef struct packed {
      logic              readdatavalid;
      logic [CSR_DW-1:0] readdata;
   } csr_rsp_t;

   // CTRL layout, start bits are pulses and never stored
   typedef struct packed {
      logic [15:0] rsvd_hi;
      logic [7:0]  count;
      logic [3:0]  rsvd_lo;
      logic [1:0]  inject_err;
      logic [1:0]  start;
   } tg_ctrl_t;

   typedef union packed {
      logic [CSR_DW-1:0] raw;
      tg_ctrl_t          ctrl;
   } csr_word_u;

endpackage

//--- source/tg_pattern_pkg.sv
// Traffic generator channel definitions
// Command and status words of a channel and the LFSR pattern rule

package tg_pattern_pkg;

   localparam int PAT_W = 16;

   typedef struct packed {
      logic             start;
      logic             inject_err;
      logic [7:0]       count;
      logic [PAT_W-1:0] seed;
   } tg_cmd_t;

   typedef struct packed {
      logic        busy;
      logic        pass;
      logic        fail;
      logic [15:0] err_count;
      logic [31:0] cycles;
   } tg_status_t;

   // Fibonacci LFSR, taps 15 13 12 10 feeding bit 0
   function automatic logic [PAT_W-1:0] lfsr_next(logic [PAT_W-1:0] state);
      logic [PAT_W-1:0] s;
      logic             fb;
      // All-zero state would lock up
      s  = (state == '0) ? {{(PAT_W-1){1'b0}}, 1'b1} : state;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[PAT_W-2:0], fb};
   endfunction

   // Memory word for one pattern state
   function automatic logic [2*PAT_W-1:0] pat_word(logic [PAT_W-1:0] state);
      return {state, ~state};
   endfunction

endpackage

//--- source/tg_pattern_ram.sv
// Memory under test for one traffic generator channel
// Single port, write on we, read data registered one cycle after the address

module tg_pattern_ram #(
   parameter int MEM_AW = 8
) (
   input  logic              tg2_cfg_if,
   input  logic              we,
   input  logic [MEM_AW-1:0] addr,
   input  logic [31:0]       wdata,
   output logic [31:0]       rdata
);

   localparam int DEPTH = 2 ** MEM_AW;

   logic [31:0] mem [DEPTH];

   always_ff @(posedge tg2_cfg_if) begin
      if (we) begin
         mem[addr] <= wdata;
      end
   end

   // Read port sees the old word on a same-address write
   always_ff @(posedge tg2_cfg_if) begin
      rdata <= mem[addr];
   end

endmodule

//--- source/tg_channel.sv
// Traffic generator channel
// Fills its memory with the LFSR pattern, reads it back and compares every word,
// then reports pass or fail, the mismatch count and the busy cycle count

module tg_channel #(
   parameter int MEM_AW = 8
) (
   input  logic                       tg2_cfg_if,
   input  logic                       arst_n,
   input  tg_pattern_pkg::tg_cmd_t    cmd,
   output tg_pattern_pkg::tg_status_t status
);

   import tg_pattern_pkg::*;

   localparam int DEPTH = 2 ** MEM_AW;
   localparam int NW    = MEM_AW + 1;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WRITE,
      ST_READ,
      ST_DRAIN
   } state_t;

   state_t            state;
   logic [MEM_AW-1:0] addr;
   logic [PAT_W-1:0]  pat;
   logic [31:0]       exp_word;
   logic              rd_valid;
   logic [15:0]       err_count;
   logic [31:0]       cycles;
   logic              pass;
   logic              fail;
   logic [NW-1:0]     n_words;
   logic              last;
   logic              mem_we;
   logic [31:0]       mem_wdata;
   logic [31:0]       mem_rdata;
   logic              mismatch;

   // Zero count runs one word, larger counts stop at the memory depth
   function automatic logic [NW-1:0] clamp_words(logic [7:0] cnt);
      int c;
      c = int'(cnt);
      if (c == 0) begin
         c = 1;
      end else if (c > DEPTH) begin
         c = DEPTH;
      end
      return NW'(c);
   endfunction

   //------------------------------
   // Datapath
   //------------------------------
   assign n_words   = clamp_words(cmd.count);
   assign last      = ({1'b0, addr} == n_words - 1'b1);
   assign mem_we    = (state == ST_WRITE);
   // Optional single-bit error on the last word written
   assign mem_wdata = pat_word(pat) ^ {31'b0, cmd.inject_err & last};
   assign mismatch  = rd_valid && (mem_rdata != exp_word);

   // Expected word trails the read address by the RAM latency
   always_ff @(posedge tg2_cfg_if) begin
      exp_word <= pat_word(pat);
   end

   //------------------------------
   // Control FSM and counters
   //------------------------------
   always_ff @(posedge tg2_cfg_if or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_IDLE;
         addr      <= '0;
         pat       <= '0;
         rd_valid  <= 1'b0;
         err_count <= '0;
         cycles    <= '0;
         pass      <= 1'b0;
         fail      <= 1'b0;
      end else begin
         rd_valid <= (state == ST_READ);
         if (state != ST_IDLE) begin
            cycles <= cycles + 1'b1;
         end
         if (mismatch) begin
            err_count <= err_count + 1'b1;
         end
         case (state)
            ST_IDLE: begin
               // Start while busy never reaches here
               if (cmd.start) begin
                  state     <= ST_WRITE;
                  addr      <= '0;
                  pat       <= cmd.seed;
                  err_count <= '0;
                  cycles    <= '0;
                  pass      <= 1'b0;
                  fail      <= 1'b0;
               end
            end
            ST_WRITE: begin
               addr <= addr + 1'b1;
               pat  <= lfsr_next(pat);
               if (last) begin
                  // Replay the sequence from the seed
                  state <= ST_READ;
                  addr  <= '0;
                  pat   <= cmd.seed;
               end
            end
            ST_READ: begin
               addr <= addr + 1'b1;
               pat  <= lfsr_next(pat);
               if (last) begin
                  state <= ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               // Wait out the last compare, then publish the result
               if (!rd_valid) begin
                  state <= ST_IDLE;
                  pass  <= (err_count == 16'd0);
                  fail  <= (err_count != 16'd0);
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_comb begin
      status.busy      = (state != ST_IDLE);
      status.pass      = pass;
      status.fail      = fail;
      status.err_count = err_count;
      status.cycles    = cycles;
   end

   tg_pattern_ram #(
      .MEM_AW (MEM_AW)
   ) u_ram (
      .tg2_cfg_if (tg2_cfg_if),
      .we         (mem_we),
      .addr       (addr),
      .wdata      (mem_wdata),
      .rdata      (mem_rdata)
   );

endmodule

//--- source/tg_csr.sv
// Host register block of the traffic generator
// Turns host writes into channel commands and serves the status of both channels

module tg_csr (
   input  logic                       tg2_cfg_if,
   input  logic                       arst_n,
   input  tg_csr_pkg::csr_req_t       csr_req,
   output tg_csr_pkg::csr_rsp_t       csr_rsp,
   output tg_pattern_pkg::tg_cmd_t    cmd0,
   output tg_pattern_pkg::tg_cmd_t    cmd1,
   input  tg_pattern_pkg::tg_status_t stat0,
   input  tg_pattern_pkg::tg_status_t stat1,
   output logic [1:0]                 tg_active
);

   import tg_csr_pkg::*;
   import tg_pattern_pkg::*;

   csr_word_u         wr_word;
   csr_word_u         rd_word;
   logic              ctrl_wr;
   logic [1:0]        busy;
   logic [1:0]        start_q;
   logic [1:0]        inject_q;
   logic [7:0]        count_q;
   logic [PAT_W-1:0]  seed0_q;
   logic [PAT_W-1:0]  seed1_q;
   logic              rvalid_q;
   logic [CSR_DW-1:0] rdata_q;

   assign wr_word   = csr_req.wdata;
   assign ctrl_wr   = csr_req.write && (csr_req.addr == ADDR_CTRL);
   assign busy      = {stat1.busy, stat0.busy};
   assign tg_active = busy;

   //------------------------------
   // Write side
   //------------------------------
   // Config of a running channel stays frozen until it finishes
   always_ff @(posedge tg2_cfg_if or negedge arst_n) begin
      if (!arst_n) begin
         start_q  <= '0;
         inject_q <= '0;
         count_q  <= '0;
         seed0_q  <= '0;
         seed1_q  <= '0;
      end else begin
         start_q <= ctrl_wr ? wr_word.ctrl.start : 2'b00;
         if (ctrl_wr) begin
            if (busy == 2'b00) begin
               count_q <= wr_word.ctrl.count;
            end
            for (int i = 0; i < 2; i++) begin
               if (!busy[i]) begin
                  inject_q[i] <= wr_word.ctrl.inject_err[i];
               end
            end
         end
         if (csr_req.write && (csr_req.addr == ADDR_SEED0) && !busy[0]) begin
            seed0_q <= wr_word.raw[PAT_W-1:0];
         end
         if (csr_req.write && (csr_req.addr == ADDR_SEED1) && !busy[1]) begin
            seed1_q <= wr_word.raw[PAT_W-1:0];
         end
      end
   end

   assign cmd0 = '{start: start_q[0], inject_err: inject_q[0], count: count_q, seed: seed0_q};
   assign cmd1 = '{start: start_q[1], inject_err: inject_q[1], count: count_q, seed: seed1_q};

   //------------------------------
   // Read side
   //------------------------------
   always_comb begin
      rd_word.raw = '0;
      case (csr_req.addr)
         ADDR_CTRL: begin
            rd_word.ctrl.inject_err = inject_q;
            rd_word.ctrl.count      = count_q;
         end
         ADDR_SEED0:   rd_word.raw[PAT_W-1:0] = seed0_q;
         ADDR_SEED1:   rd_word.raw[PAT_W-1:0] = seed1_q;
         ADDR_STATUS: begin
            rd_word.raw[2:0] = {stat0.fail, stat0.pass, stat0.busy};
            rd_word.raw[6:4] = {stat1.fail, stat1.pass, stat1.busy};
         end
         ADDR_CYCLES0: rd_word.raw = stat0.cycles;
         ADDR_CYCLES1: rd_word.raw = stat1.cycles;
         ADDR_ERRCNT0: rd_word.raw[15:0] = stat0.err_count;
         ADDR_ERRCNT1: rd_word.raw[15:0] = stat1.err_count;
         default:      rd_word.raw = '0;
      endcase
   end

   // Read data one cycle after the strobe
   always_ff @(posedge tg2_cfg_if or negedge arst_n) begin
      if (!arst_n) begin
         rvalid_q <= 1'b0;
         rdata_q  <= '0;
      end else begin
         rvalid_q <= csr_req.read;
         if (csr_req.read) begin
            rdata_q <= rd_word.raw;
         end
      end
   end

   assign csr_rsp = '{readdatavalid: rvalid_q, readdata: rdata_q};

endmodule

//--- source/tg_subsys_top.sv
// Traffic generator subsystem
// Host register block driving two independent memory test channels

module tg_subsys_top #(
   parameter int MEM_AW = 8
) (
   input  logic                 tg2_cfg_if,
   input  logic                 arst_n,
   input  tg_csr_pkg::csr_req_t csr_req,
   output tg_csr_pkg::csr_rsp_t csr_rsp,
   output logic [1:0]           tg_active
);

   import tg_pattern_pkg::*;

   tg_cmd_t    cmd0;
   tg_cmd_t    cmd1;
   tg_status_t stat0;
   tg_status_t stat1;

   tg_csr u_csr (
      .tg2_cfg_if (tg2_cfg_if),
      .arst_n     (arst_n),
      .csr_req    (csr_req),
      .csr_rsp    (csr_rsp),
      .cmd0       (cmd0),
      .cmd1       (cmd1),
      .stat0      (stat0),
      .stat1      (stat1),
      .tg_active  (tg_active)
   );

   //------------------------------
   // Channels
   //------------------------------
   tg_channel #(
      .MEM_AW (MEM_AW)
   ) u_ch0 (
      .tg2_cfg_if (tg2_cfg_if),
      .arst_n     (arst_n),
      .cmd        (cmd0),
      .status     (stat0)
   );

   tg_channel #(
      .MEM_AW (MEM_AW)
   ) u_ch1 (
      .tg2_cfg_if (tg2_cfg_if),
      .arst_n     (arst_n),
      .cmd        (cmd1),
      .status     (stat1)
   );

endmodule

//--- testbench/tb_tg_subsys.sv
// Testbench for the traffic generator subsystem
// Drives the host register bus, runs both channels and checks every read
// against a reference model of the pattern test

module tb_tg_subsys;

   timeunit 1ns;
   timeprecision 1ps;

   import tg_csr_pkg::*;
   import tg_pattern_pkg::*;

   localparam int MEM_AW = 8;
   localparam int DEPTH  = 2 ** MEM_AW;

   typedef struct packed {
      logic        pass;
      logic        fail;
      logic [15:0] errs;
      logic [31:0] cycles;
   } exp_t;

   logic        tg2_cfg_if;
   logic        arst_n;
   csr_req_t    csr_req;
   csr_rsp_t    csr_rsp;
   logic [1:0]  tg_active;

   logic [31:0] exp_q [$];
   string       name_q [$];
   longint      budget_ns = 0;

   tg_subsys_top #(
      .MEM_AW (MEM_AW)
   ) DUT (
      .tg2_cfg_if (tg2_cfg_if),
      .arst_n     (arst_n),
      .csr_req    (csr_req),
      .csr_rsp    (csr_rsp),
      .tg_active  (tg_active)
   );

   initial begin
      tg2_cfg_if = 1'b0;
      forever #5 tg2_cfg_if = ~tg2_cfg_if;
   end

   //------------------------------
   // Reference model
   //------------------------------
   function automatic logic [15:0] pattern_step(logic [15:0] s);
      logic [15:0] t;
      t = (s == 16'd0) ? 16'd1 : s;
      return {t[14:0], t[15] ^ t[13] ^ t[12] ^ t[10]};
   endfunction

   function automatic exp_t reference_run(logic [15:0] seed, logic [7:0] count, logic inject);
      exp_t        r;
      logic [31:0] words [DEPTH];
      logic [15:0] s;
      int          n;
      int          errs;
      n = (int'(count) > DEPTH) ? DEPTH : int'(count);
      s = seed;
      for (int i = 0; i < n; i++) begin
         words[i] = {s, ~s};
         s = pattern_step(s);
      end
      if (inject) begin
         words[n-1][0] = ~words[n-1][0];
      end
      // Read back against the same sequence from the seed
      s    = seed;
      errs = 0;
      for (int i = 0; i < n; i++) begin
         if (words[i] != {s, ~s}) begin
            errs++;
         end
         s = pattern_step(s);
      end
      r.errs   = 16'(errs);
      r.pass   = (errs == 0);
      r.fail   = (errs != 0);
      r.cycles = 32'(2 * n + 2);
      return r;
   endfunction

   // Idle channels: busy bits stay zero
   function automatic logic [31:0] status_word(exp_t e0, exp_t e1);
      logic [31:0] w;
      w    = '0;
      w[1] = e0.pass;
      w[2] = e0.fail;
      w[5] = e1.pass;
      w[6] = e1.fail;
      return w;
   endfunction

   function automatic logic [31:0] ctrl_word(logic [1:0] start, logic [1:0] inj, logic [7:0] cnt);
      tg_ctrl_t c;
      c            = '0;
      c.start      = start;
      c.inject_err = inj;
      c.count      = cnt;
      return c;
   endfunction

   //------------------------------
   // Checking
   //------------------------------
   task automatic stop_with_failure();
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
      assert (expected === actual) else begin
         $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         stop_with_failure();
      end
   endtask

   // Every returned read is matched against the oldest pending expectation
   always @(negedge tg2_cfg_if) begin
      string       name;
      logic [31:0] expected;
      if (csr_rsp.readdatavalid) begin
         assert (exp_q.size() != 0) else begin
            $display("Read data came back with no read outstanding");
            stop_with_failure();
         end
         name     = name_q.pop_front();
         expected = exp_q.pop_front();
         check_value(name, expected, csr_rsp.readdata);
      end
   end

   initial begin
      wait (budget_ns != 0);
      #(budget_ns);
      $display("Timeout: the run did not finish within %0d ns", budget_ns);
      stop_with_failure();
   end

   //------------------------------
   // Host bus tasks
   //------------------------------
   task automatic write_reg(logic [CSR_AW-1:0] addr, logic [31:0] data);
      @(posedge tg2_cfg_if);
      #1;
      csr_req.write = 1'b1;
      csr_req.addr  = addr;
      csr_req.wdata = data;
      @(posedge tg2_cfg_if);
      #1;
      csr_req.write = 1'b0;
   endtask

   task automatic read_reg(logic [CSR_AW-1:0] addr, logic [31:0] expected, string name);
      exp_q.push_back(expected);
      name_q.push_back(name);
      @(posedge tg2_cfg_if);
      #1;
      csr_req.read = 1'b1;
      csr_req.addr = addr;
      @(posedge tg2_cfg_if);
      #1;
      csr_req.read = 1'b0;
      while (!csr_rsp.readdatavalid) begin
         @(posedge tg2_cfg_if);
         #1;
      end
   endtask

   // Cycles from the last write until the masked channels go idle
   task automatic wait_idle(logic [1:0] mask, output int latency);
      bit seen;
      seen    = 1'b0;
      latency = 0;
      do begin
         @(posedge tg2_cfg_if);
         #1;
         latency++;
         if ((tg_active & mask) == mask) begin
            seen = 1'b1;
         end
      end while (!(seen && ((tg_active & mask) == 2'b00)));
   endtask

   //------------------------------
   // Tests
   //------------------------------
   initial begin
      logic [7:0]  n2, n3, n5;
      logic [15:0] s2, s3a, s3b, s4a, s4b, s5, s6;
      exp_t        e0, e1, idle;
      int          lat;

      arst_n   = 1'b0;
      csr_req  = '0;
      idle     = '0;
      void'($urandom(42));
      n2  = 8'(1 + $urandom % 64);
      n3  = 8'(1 + $urandom % 64);
      n5  = 8'(8 + $urandom % 56);
      s2  = 16'($urandom);
      s3a = 16'($urandom);
      s3b = s3a ^ 16'h5a5a;
      s4a = 16'($urandom);
      s4b = 16'($urandom);
      s5  = 16'($urandom);
      s6  = 16'($urandom);
      // Test 4 reuses the count of test 3
      budget_ns = 20 * 10 * (10 + (2 * n2 + 10) + 2 * (2 * n3 + 10) + (2 * n5 + 10));

      repeat (10) @(posedge tg2_cfg_if);
      #1;
      arst_n = 1'b1;

      // 1: reset values
      check_value("reset tg_active", 32'd0, 32'(tg_active));
      read_reg(ADDR_STATUS, 32'd0, "reset STATUS");
      read_reg(ADDR_CYCLES0, 32'd0, "reset CYCLES0");
      read_reg(8'h03, 32'd0, "unmapped 0x03");
      read_reg(8'hff, 32'd0, "unmapped 0xff");

      // 2: channel 0 alone
      e0 = reference_run(s2, n2, 1'b0);
      write_reg(ADDR_SEED0, {16'd0, s2});
      write_reg(ADDR_CTRL, ctrl_word(2'b01, 2'b00, n2));
      wait_idle(2'b01, lat);
      check_value("ch0 run latency", 32'(2 * n2 + 3), 32'(lat));
      read_reg(ADDR_STATUS, status_word(e0, idle), "ch0 STATUS");
      read_reg(ADDR_ERRCNT0, {16'd0, e0.errs}, "ch0 ERRCNT0");
      read_reg(ADDR_CYCLES0, e0.cycles, "ch0 CYCLES0");

      // 3: both channels in one write
      e0 = reference_run(s3a, n3, 1'b0);
      e1 = reference_run(s3b, n3, 1'b0);
      write_reg(ADDR_SEED0, {16'd0, s3a});
      write_reg(ADDR_SEED1, {16'd0, s3b});
      write_reg(ADDR_CTRL, ctrl_word(2'b11, 2'b00, n3));
      wait_idle(2'b11, lat);
      check_value("dual run latency", 32'(2 * n3 + 3), 32'(lat));
      read_reg(ADDR_STATUS, status_word(e0, e1), "dual STATUS");
      read_reg(ADDR_CYCLES0, e0.cycles, "dual CYCLES0");
      read_reg(ADDR_CYCLES1, e1.cycles, "dual CYCLES1");
      read_reg(ADDR_ERRCNT1, {16'd0, e1.errs}, "dual ERRCNT1");

      // 4: error injected on channel 1 only
      e0 = reference_run(s4a, n3, 1'b0);
      e1 = reference_run(s4b, n3, 1'b1);
      write_reg(ADDR_SEED0, {16'd0, s4a});
      write_reg(ADDR_SEED1, {16'd0, s4b});
      write_reg(ADDR_CTRL, ctrl_word(2'b11, 2'b10, n3));
      wait_idle(2'b11, lat);
      read_reg(ADDR_STATUS, status_word(e0, e1), "inject STATUS");
      read_reg(ADDR_ERRCNT0, {16'd0, e0.errs}, "inject ERRCNT0");
      read_reg(ADDR_ERRCNT1, {16'd0, e1.errs}, "inject ERRCNT1");

      // 5: restart while busy has no effect
      e0 = reference_run(s5, n5, 1'b0);
      write_reg(ADDR_SEED0, {16'd0, s5});
      write_reg(ADDR_CTRL, ctrl_word(2'b01, 2'b00, n5));
      repeat (3) @(posedge tg2_cfg_if);
      write_reg(ADDR_CTRL, ctrl_word(2'b01, 2'b00, n5 + 8'd17));
      wait_idle(2'b01, lat);
      repeat (5) begin
         @(posedge tg2_cfg_if);
         #1;
         check_value("no restart tg_active", 32'd0, 32'(tg_active));
      end
      read_reg(ADDR_CYCLES0, e0.cycles, "restart CYCLES0");
      // Channel 1 still holds its result from the inject run
      read_reg(ADDR_STATUS, status_word(e0, e1), "restart STATUS");
      write_reg(ADDR_SEED1, {16'd0, s6});
      read_reg(ADDR_SEED1, {16'd0, s6}, "SEED1 readback");
      read_reg(ADDR_SEED0, {16'd0, s5}, "SEED0 readback");

      wait (exp_q.size() == 0);
      repeat (2) @(posedge tg2_cfg_if);
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- files.f
source/tg_csr_pkg.sv
source/tg_pattern_pkg.sv
source/tg_pattern_ram.sv
source/tg_channel.sv
source/tg_csr.sv
source/tg_subsys_top.sv
testbench/tb_tg_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the traffic generator testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module tb_tg_subsys \
   -Mdir obj_dir -o sim_tb \
   -f files.f

# The simulator exit status is not used, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx ">>> PASS" sim.log; then
   exit 0
else
   echo "Simulation did not pass, see sim.log"
   exit 1
fi
